// File: rtl/sysex_pkg.sv
package sysex_pkg;

    // command nibble, upper half of the command/channel byte
    typedef enum logic [3:0] {
        op_ctrl_write = 4'h1,
        op_bank_load  = 4'h2,
        op_dump_req   = 4'h3,
        op_patch_load = 4'h7
    } sysex_op_e;

    typedef enum logic [1:0] {
        mode_idle,
        mode_ctrl,
        mode_bank,
        mode_patch
    } rx_mode_e;

    typedef enum logic [1:0] {
        tx_idle,
        tx_header,
        tx_body,
        tx_end
    } tx_state_e;

    localparam logic [7:0] sysex_start = 8'hF0;
    localparam logic [7:0] sysex_end   = 8'hF7;
    localparam logic [7:0] edu_id      = 8'h7D;    // educational use

    localparam logic [7:0] patch_len = 8'd224;     // data bytes in one patch
    localparam logic [7:0] block_len = 8'd64;      // bytes per layout block

    // blocks 0..2 map to banks 0..2, the short last block goes to bank 5
    function automatic logic [2:0] patch_bank_of(input logic [1:0] blk);
        return (blk == 2'd3) ? 3'd5 : {1'b0, blk};
    endfunction

endpackage

// File: rtl/sysex_rx_if.sv
`timescale 1ns/10ps

interface sysex_rx_if;

    logic       in_sysex;     // high between F0 and the closing pulse
    logic [7:0] byte_num;     // 0 = F0, 1 = manufacturer, 2 = cmd/channel
    logic [7:0] data;
    logic       byte_stb;     // one pulse per counted byte

    modport tracker (
        output in_sysex,
        output byte_num,
        output data,
        output byte_stb
    );

    modport decoder (
        input in_sysex,
        input byte_num,
        input data,
        input byte_stb
    );

endinterface

// File: rtl/sysex_wr_if.sv
`timescale 1ns/10ps

interface sysex_wr_if;

    logic       wr_en;        // one write per pulse
    logic [2:0] bank;
    logic [6:0] addr;
    logic [7:0] wr_data;

    modport src (
        output wr_en,
        output bank,
        output addr,
        output wr_data
    );

    modport sink (
        input wr_en,
        input bank,
        input addr,
        input wr_data
    );

endinterface

// File: rtl/midi_byte_tracker.sv
`timescale 1ns/10ps

module midi_byte_tracker (
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic [7:0] rx_byte,
    input  logic       rx_strobe,
    sysex_rx_if.tracker rx
);

    logic [7:0] next_num;    // number given to the next data byte

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            rx.in_sysex <= 1'b0;
            rx.byte_num <= 8'd0;
            rx.data     <= 8'd0;
            rx.byte_stb <= 1'b0;
            next_num    <= 8'd0;
        end else begin
            rx.byte_stb <= 1'b0;
            // real-time bytes F8..FF pass through a message untouched
            if (rx_strobe && rx_byte < 8'hF8) begin
                if (rx_byte == sysex_pkg::sysex_start) begin
                    rx.in_sysex <= 1'b1;    // also restarts an open message
                    rx.byte_num <= 8'd0;
                    rx.data     <= rx_byte;
                    rx.byte_stb <= 1'b1;
                    next_num    <= 8'd1;
                end else if (rx.in_sysex) begin
                    if (rx_byte == sysex_pkg::sysex_end) begin
                        rx.in_sysex <= 1'b0;    // closing byte still gets a pulse
                        rx.byte_num <= next_num;
                        rx.data     <= rx_byte;
                        rx.byte_stb <= 1'b1;
                    end else if (rx_byte[7]) begin
                        rx.in_sysex <= 1'b0;    // other status byte, drop quietly
                    end else begin
                        rx.byte_num <= next_num;
                        rx.data     <= rx_byte;
                        rx.byte_stb <= 1'b1;
                        if (next_num != 8'hFF) begin
                            next_num <= next_num + 8'd1;    // saturate on long messages
                        end
                    end
                end
            end
        end
    end

endmodule

// File: rtl/sysex_rx_decoder.sv
`timescale 1ns/10ps

module sysex_rx_decoder (
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic [3:0] midi_ch,
    sysex_rx_if.decoder rx,
    sysex_wr_if.src     wr,
    output logic       syx_cmd,
    output logic       auto_syx_cmd,
    output logic       dump_req
);

    sysex_pkg::rx_mode_e mode;
    logic                edu_use;     // byte 1 was 7D
    logic [7:0]          load_cnt;    // payload bytes taken so far

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            mode         <= sysex_pkg::mode_idle;
            edu_use      <= 1'b0;
            load_cnt     <= 8'd0;
            syx_cmd      <= 1'b0;
            auto_syx_cmd <= 1'b0;
            dump_req     <= 1'b0;
            wr.wr_en     <= 1'b0;
            wr.bank      <= 3'd0;
            wr.addr      <= 7'd0;
            wr.wr_data   <= 8'd0;
        end else begin
            wr.wr_en <= 1'b0;
            syx_cmd  <= 1'b0;
            dump_req <= 1'b0;
            if (rx.byte_stb) begin
                if (rx.byte_num == 8'd0) begin
                    mode         <= sysex_pkg::mode_idle;    // fresh F0
                    edu_use      <= 1'b0;
                    auto_syx_cmd <= 1'b0;
                end else if (rx.byte_num == 8'd1) begin
                    edu_use <= (rx.data == sysex_pkg::edu_id);
                end else if (rx.byte_num == 8'd2) begin
                    mode     <= sysex_pkg::mode_idle;
                    load_cnt <= 8'd0;
                    if (edu_use && rx.data[3:0] == midi_ch) begin
                        case (sysex_pkg::sysex_op_e'(rx.data[7:4]))
                            sysex_pkg::op_ctrl_write: mode <= sysex_pkg::mode_ctrl;
                            sysex_pkg::op_bank_load:  mode <= sysex_pkg::mode_bank;
                            sysex_pkg::op_dump_req:   dump_req <= 1'b1;
                            sysex_pkg::op_patch_load: begin
                                mode         <= sysex_pkg::mode_patch;
                                auto_syx_cmd <= 1'b1;
                            end
                            default: ;    // unknown opcode
                        endcase
                    end
                end else if (rx.data == sysex_pkg::sysex_end) begin
                    if (mode == sysex_pkg::mode_ctrl && rx.byte_num == 8'd6) begin
                        syx_cmd <= 1'b1;    // confirm a complete control write
                    end
                    mode         <= sysex_pkg::mode_idle;
                    auto_syx_cmd <= 1'b0;
                end else begin
                    case (mode)
                        sysex_pkg::mode_ctrl: begin
                            if (rx.byte_num == 8'd3) begin
                                wr.bank <= rx.data[2:0];
                            end else if (rx.byte_num == 8'd4) begin
                                wr.addr <= rx.data[6:0];
                            end else if (rx.byte_num == 8'd5) begin
                                wr.wr_data <= rx.data;
                                wr.wr_en   <= 1'b1;
                            end
                        end
                        sysex_pkg::mode_bank: begin
                            if (rx.byte_num == 8'd3) begin
                                wr.bank      <= rx.data[2:0];
                                auto_syx_cmd <= 1'b1;
                            end else if (load_cnt < 8'd128) begin
                                wr.addr    <= load_cnt[6:0];    // sequential from 0
                                wr.wr_data <= rx.data;
                                wr.wr_en   <= 1'b1;
                                load_cnt   <= load_cnt + 8'd1;
                            end
                        end
                        sysex_pkg::mode_patch: begin
                            if (load_cnt < sysex_pkg::patch_len) begin
                                wr.bank    <= sysex_pkg::patch_bank_of(load_cnt[7:6]);
                                wr.addr    <= 7'(load_cnt % sysex_pkg::block_len);
                                wr.wr_data <= rx.data;
                                wr.wr_en   <= 1'b1;
                                load_cnt   <= load_cnt + 8'd1;
                            end
                        end
                        default: ;
                    endcase
                end
            end else if (!rx.in_sysex) begin
                mode         <= sysex_pkg::mode_idle;    // message aborted or closed
                auto_syx_cmd <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/patch_dump_tx.sv
`timescale 1ns/10ps

module patch_dump_tx (
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic [3:0] midi_ch,
    input  logic       dump_req,
    input  logic       midi_out_ready,
    output logic       dump_active,
    output logic [2:0] rd_bank,
    output logic [6:0] rd_addr,
    input  logic [7:0] rd_data,
    output logic [7:0] midi_out_data,
    output logic       midi_out_strobe
);

    sysex_pkg::tx_state_e state;
    logic [7:0]           cnt;    // position within the current state

    assign dump_active = (state != sysex_pkg::tx_idle);
    assign rd_bank     = sysex_pkg::patch_bank_of(cnt[7:6]);
    assign rd_addr     = 7'(cnt % sysex_pkg::block_len);

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            state           <= sysex_pkg::tx_idle;
            cnt             <= 8'd0;
            midi_out_data   <= 8'hFF;    // line idles high
            midi_out_strobe <= 1'b0;
        end else begin
            midi_out_strobe <= 1'b0;
            case (state)
                sysex_pkg::tx_idle: begin
                    cnt <= 8'd0;
                    if (dump_req) begin
                        state <= sysex_pkg::tx_header;
                    end
                end
                sysex_pkg::tx_header: begin
                    if (midi_out_ready) begin
                        midi_out_strobe <= 1'b1;
                        cnt             <= cnt + 8'd1;
                        if (cnt == 8'd0) begin
                            midi_out_data <= sysex_pkg::sysex_start;
                        end else if (cnt == 8'd1) begin
                            midi_out_data <= sysex_pkg::edu_id;
                        end else begin
                            // reply is itself a patch load message
                            midi_out_data <= {sysex_pkg::op_patch_load, midi_ch};
                            cnt           <= 8'd0;
                            state         <= sysex_pkg::tx_body;
                        end
                    end
                end
                sysex_pkg::tx_body: begin
                    if (midi_out_ready) begin
                        midi_out_data   <= rd_data;    // layout address comes from cnt
                        midi_out_strobe <= 1'b1;
                        cnt             <= cnt + 8'd1;
                        if (cnt == sysex_pkg::patch_len - 8'd1) begin
                            cnt   <= 8'd0;
                            state <= sysex_pkg::tx_end;
                        end
                    end
                end
                sysex_pkg::tx_end: begin
                    if (cnt != 8'd0) begin
                        midi_out_data <= 8'hFF;    // drop active one cycle after F7
                        state         <= sysex_pkg::tx_idle;
                    end else if (midi_out_ready) begin
                        midi_out_data   <= sysex_pkg::sysex_end;
                        midi_out_strobe <= 1'b1;
                        cnt             <= 8'd1;
                    end
                end
                default: state <= sysex_pkg::tx_idle;
            endcase
        end
    end

endmodule

// File: rtl/patch_param_store.sv
`timescale 1ns/10ps

module patch_param_store (
    input  logic       reg_clk,
    sysex_wr_if.sink   wr,
    input  logic       dump_active,
    input  logic [2:0] rd_bank,
    input  logic [6:0] rd_addr,
    output logic [7:0] rd_data
);

    logic [7:0] mem [0:1023];    // 8 banks x 128 bytes, bank in the upper bits

    // hold the patch steady while it is being sent out
    always_ff @(posedge reg_clk) begin
        if (wr.wr_en && !dump_active) begin
            mem[{wr.bank, wr.addr}] <= wr.wr_data;
        end
    end

    assign rd_data = mem[{rd_bank, rd_addr}];    // async read for the transmitter

endmodule

// File: rtl/sysex_top.sv
`timescale 1ns/10ps

module sysex_top (
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic [3:0] midi_ch,
    input  logic [7:0] rx_byte,
    input  logic       rx_strobe,
    input  logic       midi_out_ready,
    output logic [7:0] midi_out_data,
    output logic       midi_out_strobe,
    output logic       syx_cmd,
    output logic       auto_syx_cmd,
    output logic       dump_active
);

    sysex_rx_if rx_bus ();
    sysex_wr_if wr_bus ();

    logic       dump_req;
    logic [2:0] rd_bank;
    logic [6:0] rd_addr;
    logic [7:0] rd_data;

    midi_byte_tracker u_tracker (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .rx_byte     (rx_byte),
        .rx_strobe   (rx_strobe),
        .rx          (rx_bus.tracker)
    );

    sysex_rx_decoder u_decoder (
        .reg_clk      (reg_clk),
        .reset_reg_N  (reset_reg_N),
        .midi_ch      (midi_ch),
        .rx           (rx_bus.decoder),
        .wr           (wr_bus.src),
        .syx_cmd      (syx_cmd),
        .auto_syx_cmd (auto_syx_cmd),
        .dump_req     (dump_req)
    );

    patch_dump_tx u_dump_tx (
        .reg_clk         (reg_clk),
        .reset_reg_N     (reset_reg_N),
        .midi_ch         (midi_ch),
        .dump_req        (dump_req),
        .midi_out_ready  (midi_out_ready),
        .dump_active     (dump_active),
        .rd_bank         (rd_bank),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .midi_out_data   (midi_out_data),
        .midi_out_strobe (midi_out_strobe)
    );

    patch_param_store u_store (
        .reg_clk     (reg_clk),
        .wr          (wr_bus.sink),
        .dump_active (dump_active),
        .rd_bank     (rd_bank),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

// File: verification/sysex_tb.sv
`timescale 1ns/10ps

module sysex_tb;

    logic       reg_clk = 1'b0;
    logic       reset_reg_N;
    logic       rx_strobe;
    logic       midi_out_ready;
    logic       midi_out_strobe;
    logic       syx_cmd;
    logic       auto_syx_cmd;
    logic       dump_active;
    logic [3:0] midi_ch;
    logic [7:0] rx_byte;
    logic [7:0] midi_out_data;

    logic [7:0] model [0:1023];    // expected store contents, bank in the upper bits
    bit         known [0:1023];    // set once a model byte is defined
    int         seed = 32'h2ed8;
    int         errors = 0;
    int         checks = 0;
    int         first_err = 0;
    string      test_name;

    sysex_top dut (.*);

    always #10 reg_clk = ~reg_clk;

    assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
                     !midi_out_ready |=> !midi_out_strobe)
        else begin
            errors++;
            $display("output byte sent with ready low during %s", test_name);
        end

    assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
                     $fell(dump_active)
                     |-> $past(midi_out_strobe) && $past(midi_out_data) == 8'hF7)
        else begin
            errors++;
            $display("dump_active fell without a closing F7 during %s", test_name);
        end

    // banks 0..2 hold 64 patch bytes each, bank 5 the last 32
    function automatic int store_index(input int i);
        return (i < 192) ? (i / 64) * 128 + i % 64 : 640 + i - 192;
    endfunction

    // MIDI data bytes keep bit 7 clear
    function automatic logic [7:0] random_data();
        return {1'b0, 7'($random(seed))};
    endfunction

    task automatic check_value(input string what, input logic [7:0] want, input logic [7:0] got);
        checks++;
        assert (got === want)
            else begin
                errors++;
                $display("Fail %s %s expected %02h actual %02h", test_name, what, want, got);
            end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout in %s while waiting for %s", test_name, what);
    endtask

    task automatic finish_test();
        $display("test %s %s", test_name, (errors == first_err) ? "ok" : "failed");
        first_err = errors;
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge reg_clk);
        rx_byte   <= b;
        rx_strobe <= 1'b1;
        @(posedge reg_clk);
        rx_strobe <= 1'b0;
    endtask

    // F0, manufacturer, command/channel, payload, F7
    task automatic send_msg(input logic [7:0] id, input logic [7:0] cmd,
                            input logic [7:0] data [$], input bit rt);
        int pulses;
        bit confirm;
        confirm = (id == 8'h7D) && (cmd == {4'h1, midi_ch}) && (data.size() == 3)
                  && !data[2][7];    // complete control write for this channel
        send_byte(8'hF0);
        send_byte(id);
        send_byte(cmd);
        foreach (data[i]) begin
            if (rt && i % 16 == 5) begin
                send_byte(8'hF8);    // timing clock inside the payload
            end
            send_byte(data[i]);
            if (i > 0) begin
                check_value("auto_syx_cmd", {7'd0, cmd[7:4] != 4'h1}, {7'd0, auto_syx_cmd});
            end
        end
        send_byte(8'hF7);
        pulses = 0;
        repeat (4) begin
            @(posedge reg_clk);
            pulses += syx_cmd;
        end
        check_value("syx_cmd pulses", {7'd0, confirm}, 8'(pulses));
        check_value("auto_syx_cmd after F7", 8'd0, {7'd0, auto_syx_cmd});
    endtask

    task automatic ctrl_write(input logic [7:0] id, input logic [3:0] ch, input int idx,
                              input logic [7:0] val);
        logic [7:0] data [$];
        data.push_back(8'(idx / 128));
        data.push_back(8'(idx % 128));
        data.push_back(val);
        send_msg(id, {sysex_pkg::op_ctrl_write, ch}, data, 1'b0);
    endtask

    task automatic load_patch(input bit rt);
        logic [7:0] data [$];
        repeat (224) data.push_back(random_data());
        foreach (data[i]) begin
            model[store_index(i)] = data[i];
            known[store_index(i)] = 1'b1;
        end
        send_msg(8'h7D, {sysex_pkg::op_patch_load, midi_ch}, data, rt);
    endtask

    task automatic start_dump();
        logic [7:0] none [$];
        int t = 0;
        midi_out_ready <= 1'b0;    // dump waits at its first byte
        send_msg(8'h7D, {sysex_pkg::op_dump_req, midi_ch}, none, 1'b0);
        while (!dump_active && t < 20) begin
            @(posedge reg_clk);
            t++;
        end
        if (!dump_active) begin
            report_timeout("dump_active");
        end
    endtask

    task automatic collect_dump(input bit rand_ready);
        logic [7:0] got [$];
        logic [7:0] want;
        int idle = 0;
        int t = 0;
        while (idle < 4 && t < 5000) begin
            @(posedge reg_clk);
            midi_out_ready <= rand_ready ? 1'($random(seed)) : 1'b1;
            if (midi_out_strobe) begin
                got.push_back(midi_out_data);
            end
            if (got.size() >= 228 && !dump_active) begin
                idle++;    // quiet cycles catch any extra byte
            end
            t++;
        end
        if (idle < 4) begin
            report_timeout("the end of the dump");
        end
        check_value("dump length", 8'd228, 8'(got.size()));
        foreach (got[i]) begin
            if (i < 3 || i == 227) begin
                want = (i == 0) ? 8'hF0 : (i == 1) ? 8'h7D : (i == 2) ? {4'h7, midi_ch} : 8'hF7;
                check_value("dump framing", want, got[i]);
            end else if (i < 227 && known[store_index(i - 3)]) begin
                check_value("dump data", model[store_index(i - 3)], got[i]);
            end
        end
        midi_out_ready <= 1'b1;
    endtask

    initial begin
        logic [7:0] data [$];
        int idx;
        reset_reg_N    = 1'b0;
        rx_strobe      = 1'b0;
        rx_byte        = 8'h00;
        midi_ch        = 4'h5;
        midi_out_ready = 1'b1;
        repeat (2) @(posedge reg_clk);
        reset_reg_N <= 1'b1;

        test_name = "reset";
        @(posedge reg_clk);
        check_value("midi_out_data", 8'hFF, midi_out_data);
        check_value("flags", 8'd0, {4'd0, midi_out_strobe, syx_cmd, auto_syx_cmd, dump_active});
        finish_test();

        test_name = "ctrl_write";
        idx = 128 * ({$random(seed)} % 3) + {$random(seed)} % 64;    // inside the layout
        model[idx] = random_data();
        known[idx] = 1'b1;
        ctrl_write(8'h7D, midi_ch, idx, model[idx]);
        start_dump();
        collect_dump(1'b0);
        finish_test();

        test_name = "patch_round_trip";
        load_patch(1'b0);
        start_dump();
        collect_dump(1'b1);
        finish_test();

        test_name = "bank_load";
        data.push_back(8'h01);
        for (int a = 0; a < 128; a++) begin
            data.push_back(random_data());
            model[128 + a] = data[a + 1];
            known[128 + a] = 1'b1;
        end
        send_msg(8'h7D, {sysex_pkg::op_bank_load, midi_ch}, data, 1'b0);
        start_dump();
        collect_dump(1'b0);
        finish_test();

        test_name = "filtering";
        load_patch(1'b1);
        idx = {$random(seed)} % 64;
        ctrl_write(8'h7D, midi_ch + 4'd1, idx, {1'b0, ~model[idx][6:0]});    // other channel
        ctrl_write(8'h7E, midi_ch, idx, {1'b0, ~model[idx][6:0]});    // other manufacturer
        ctrl_write(8'h7D, midi_ch, idx, 8'h90);                 // note-on cuts the message
        start_dump();
        collect_dump(1'b0);
        finish_test();

        test_name = "write_gating";
        idx = 256 + {$random(seed)} % 64;
        start_dump();
        ctrl_write(8'h7D, midi_ch, idx, {1'b0, ~model[idx][6:0]});    // lands while held
        collect_dump(1'b0);
        start_dump();
        collect_dump(1'b0);
        finish_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/sysex_pkg.sv
rtl/sysex_rx_if.sv
rtl/sysex_wr_if.sv
rtl/midi_byte_tracker.sv
rtl/sysex_rx_decoder.sv
rtl/patch_dump_tx.sv
rtl/patch_param_store.sv
rtl/sysex_top.sv
verification/sysex_tb.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --top-module sysex_tb -f verilog.f
	./obj_dir/Vsysex_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
